// File: dv/raster_front_end_assert.sv
`timescale 1ns/1ps
`default_nettype none

module raster_front_end_assert (
    input logic                        clock,
    input logic                        reset,
    input raster_bus_pkg::bus_addr_t   master_address,
    input logic                        master_read,
    input raster_bus_pkg::bus_be_t     master_byteenable,
    input logic                        master_waitrequest,
    input logic                        stall_in,
    input logic                        done_out,
    input logic                        triangle_valid,
    input raster_vertex_pkg::record_t  triangle_record,
    input raster_vertex_pkg::coord_t   bbox_min_x,
    input raster_vertex_pkg::coord_t   bbox_max_x,
    input raster_vertex_pkg::coord_t   bbox_min_y,
    input raster_vertex_pkg::coord_t   bbox_max_y,
    input logic                        fifo_write,
    input logic                        fifo_full
);

    int failure_count = 0;

    address_stable: assert property (@(posedge clock) disable iff (!reset)
        master_read && master_waitrequest |=> master_read && $stable(master_address))
        else begin
            failure_count++;
            $error("read request changed while waitrequest was high");
        end

    byteenable_ones: assert property (@(posedge clock) disable iff (!reset)
        master_read |-> master_byteenable == '1)
        else begin
            failure_count++;
            $error("byte enables not all ones during a read");
        end

    // Everything the rasterizer sees holds under stall
    output_hold: assert property (@(posedge clock) disable iff (!reset)
        triangle_valid && stall_in |=> triangle_valid && $stable(triangle_record) &&
        $stable(bbox_min_x) && $stable(bbox_max_x) &&
        $stable(bbox_min_y) && $stable(bbox_max_y))
        else begin
            failure_count++;
            $error("triangle outputs changed under stall");
        end

    done_sticky: assert property (@(posedge clock) disable iff (!reset)
        done_out |=> done_out)
        else begin
            failure_count++;
            $error("done_out fell after it had risen");
        end

    no_write_when_full: assert property (@(posedge clock) disable iff (!reset)
        !(fifo_write && fifo_full))
        else begin
            failure_count++;
            $error("record FIFO written while full");
        end

    reset_state: assert property (@(posedge clock)
        !reset |-> !triangle_valid && !master_read && !done_out)
        else begin
            failure_count++;
            $error("outputs not low during reset");
        end

endmodule

`default_nettype wire

// File: dv/raster_front_end_tb.sv
`timescale 1ns/1ps
`default_nettype none

module raster_front_end_tb;

    typedef struct packed {
        raster_vertex_pkg::tri_count_t count;
        raster_bus_pkg::bus_addr_t     base;
        logic [7:0]                    stall_pct;
        logic [7:0]                    wait_pct;
        logic [7:0]                    max_delay;
    } test_row_t;

    localparam int num_rows     = 5;
    localparam int drain_cycles = 20;

    logic clock;
    logic reset;
    logic fetch_enable;
    logic stall_in;
    logic master_read;
    logic master_readdatavalid;
    logic master_waitrequest;
    logic done_out;
    logic triangle_valid;
    raster_bus_pkg::bus_addr_t     vertex_buffer_base;
    raster_bus_pkg::bus_addr_t     master_address;
    raster_bus_pkg::bus_be_t       master_byteenable;
    raster_bus_pkg::bus_data_t     master_readdata;
    raster_vertex_pkg::record_t    triangle_record;
    raster_vertex_pkg::coord_t     bbox_min_x;
    raster_vertex_pkg::coord_t     bbox_max_x;
    raster_vertex_pkg::coord_t     bbox_min_y;
    raster_vertex_pkg::coord_t     bbox_max_y;
    raster_bus_pkg::bus_addr_t     mem_base;
    raster_vertex_pkg::tri_count_t mem_count;
    logic [7:0]                    mem_wait_pct;
    logic [7:0]                    mem_max_delay;

    test_row_t test_rows [num_rows];
    integer seed = 32'hca97b98b;
    int cycle_count = 0;
    int timeout_limit = 0;
    int words_returned = 0;

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    vertex_memory_model i_memory (
        .clock         (clock),
        .reset         (reset),
        .address       (master_address),
        .read          (master_read),
        .readdata      (master_readdata),
        .readdatavalid (master_readdatavalid),
        .waitrequest   (master_waitrequest),
        .buffer_base   (mem_base),
        .tri_count     (mem_count),
        .wait_pct      (mem_wait_pct),
        .max_delay     (mem_max_delay)
    );

    raster_front_end i_raster_front_end (
        .clock                (clock),
        .reset                (reset),
        .fetch_enable         (fetch_enable),
        .vertex_buffer_base   (vertex_buffer_base),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_byteenable    (master_byteenable),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .master_waitrequest   (master_waitrequest),
        .stall_in             (stall_in),
        .done_out             (done_out),
        .triangle_valid       (triangle_valid),
        .triangle_record      (triangle_record),
        .bbox_min_x           (bbox_min_x),
        .bbox_max_x           (bbox_max_x),
        .bbox_min_y           (bbox_min_y),
        .bbox_max_y           (bbox_max_y)
    );

    bind raster_front_end raster_front_end_assert i_assert (
        .*,
        .fifo_write (i_fetch.record_write),
        .fifo_full  (i_fetch.fifo_full)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_record(input string name, input raster_vertex_pkg::record_t got,
                                input raster_vertex_pkg::record_t expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_coord(input string name, input raster_vertex_pkg::coord_t got,
                               input raster_vertex_pkg::coord_t expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_count(input string name, input raster_vertex_pkg::tri_count_t got,
                               input raster_vertex_pkg::tri_count_t expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    // Record k, word j lives at base + 4 + 60k + 4j
    function automatic raster_vertex_pkg::record_t build_record(
        input raster_bus_pkg::bus_addr_t base,
        input raster_vertex_pkg::tri_count_t k
    );
        raster_vertex_pkg::record_t rec;
        raster_bus_pkg::bus_addr_t addr;
        for (int j = 0; j < raster_vertex_pkg::record_words; j++) begin
            addr = base + raster_bus_pkg::bus_addr_t'(raster_bus_pkg::word_bytes *
                   (1 + raster_vertex_pkg::record_words * int'(k) + j));
            rec[32*j +: 32] = i_memory.word_at(addr, base);
        end
        return rec;
    endfunction

    function automatic raster_vertex_pkg::coord_t extreme_coord(
        input raster_vertex_pkg::record_t rec,
        input int offset,
        input logic want_max
    );
        raster_vertex_pkg::coord_t best;
        raster_vertex_pkg::coord_t c;
        best = rec[32*offset +: 32];
        for (int v = 1; v < 3; v++) begin
            c = rec[32*(v*raster_vertex_pkg::vertex_words + offset) +: 32];
            if (want_max ? (c > best) : (c < best)) begin
                best = c;
            end
        end
        return best;
    endfunction

    ////////////////////
    // Per-cycle driving and checking
    ////////////////////

    // Outputs are stable at the falling edge; a triangle shown now with
    // stall low is taken at the next rising edge
    task automatic watch_cycle(input test_row_t row,
                               inout raster_vertex_pkg::tri_count_t delivered,
                               inout logic done_seen);
        raster_vertex_pkg::record_t expected;
        @(negedge clock);
        stall_in = ($unsigned($random(seed)) % 100) < row.stall_pct;
        if (done_seen && !done_out) begin
            abort_run("done_out dropped after it had gone high");
        end
        done_seen = done_seen | done_out;
        // Count word plus every record word must be back before done
        if (done_out &&
            words_returned < 1 + raster_vertex_pkg::record_words * int'(row.count)) begin
            abort_run("done_out rose before all records were read back");
        end
        if (triangle_valid && !stall_in) begin
            expected = build_record(row.base, delivered);
            check_record("triangle_record", triangle_record, expected);
            check_coord("bbox_min_x", bbox_min_x,
                        extreme_coord(expected, raster_vertex_pkg::x_word, 1'b0));
            check_coord("bbox_max_x", bbox_max_x,
                        extreme_coord(expected, raster_vertex_pkg::x_word, 1'b1));
            check_coord("bbox_min_y", bbox_min_y,
                        extreme_coord(expected, raster_vertex_pkg::y_word, 1'b0));
            check_coord("bbox_max_y", bbox_max_y,
                        extreme_coord(expected, raster_vertex_pkg::y_word, 1'b1));
            delivered = delivered + 1;
        end
    endtask

    task automatic run_row(input test_row_t row);
        raster_vertex_pkg::tri_count_t delivered;
        logic done_seen;
        fetch_enable  = 1'b0;
        stall_in      = 1'b0;
        mem_base      = row.base;
        mem_count     = row.count;
        mem_wait_pct  = row.wait_pct;
        mem_max_delay = row.max_delay;
        i_clock_gen.pulse_reset();
        if (triangle_valid !== 1'b0 || master_read !== 1'b0 || done_out !== 1'b0) begin
            abort_run("Outputs were not low after reset");
        end
        vertex_buffer_base = row.base;
        fetch_enable       = 1'b1;
        delivered          = '0;
        done_seen          = 1'b0;
        while (!done_out || delivered < row.count) begin
            watch_cycle(row, delivered, done_seen);
        end
        // Anything arriving now is a repeat or an extra triangle
        repeat (drain_cycles) watch_cycle(row, delivered, done_seen);
        check_count("delivered triangles", delivered, row.count);
    endtask

    // Words handed back by the memory since the last reset
    always @(posedge clock) begin
        if (!reset) begin
            words_returned <= 0;
        end else if (master_readdatavalid) begin
            words_returned <= words_returned + 1;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            abort_run($sformatf("Timeout, no finish within %0d cycles", timeout_limit));
        end
    end

    always @(negedge clock) begin
        if (i_raster_front_end.i_assert.failure_count != 0) begin
            abort_run("A bound assertion failed");
        end
    end

    initial begin
        fetch_enable       = 1'b0;
        stall_in           = 1'b0;
        vertex_buffer_base = '0;
        mem_base           = '0;
        mem_count          = '0;
        mem_wait_pct       = '0;
        mem_max_delay      = '0;
        // count, base, stall %, waitrequest %, max read delay
        test_rows[0] = '{32'd6,  26'h000_1000, 8'd0,  8'd0,  8'd1};
        test_rows[1] = '{32'd9,  26'h002_0400, 8'd98, 8'd10, 8'd3};
        test_rows[2] = '{32'd7,  26'h030_0000, 8'd20, 8'd70, 8'd12};
        test_rows[3] = '{32'd0,  26'h000_0800, 8'd30, 8'd30, 8'd4};
        test_rows[4] = '{32'd12, 26'h100_0040, 8'd50, 8'd40, 8'd6};
        timeout_limit = 2000;
        for (int r = 0; r < num_rows; r++) begin
            timeout_limit += int'(test_rows[r].count) * raster_vertex_pkg::record_words *
                             (int'(test_rows[r].max_delay) + 4);
        end
        for (int r = 0; r < num_rows; r++) begin
            run_row(test_rows[r]);
        end
        if (i_raster_front_end.i_assert.failure_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures",
                                i_raster_front_end.i_assert.failure_count));
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int reset_cycles = 16;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial reset = 1'b0;

    // Reset changes on the falling edge, away from the sampling edge
    task automatic pulse_reset();
        @(negedge clock);
        reset = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b1;
    endtask

endmodule

`default_nettype wire

// File: dv/vertex_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_memory_model (
    input  logic                          clock,
    input  logic                          reset,
    input  raster_bus_pkg::bus_addr_t     address,
    input  logic                          read,
    output raster_bus_pkg::bus_data_t     readdata,
    output logic                          readdatavalid,
    output logic                          waitrequest,
    input  raster_bus_pkg::bus_addr_t     buffer_base,
    input  raster_vertex_pkg::tri_count_t tri_count,
    input  logic [7:0]                    wait_pct,
    input  logic [7:0]                    max_delay
);

    integer seed = 32'hca97b98b;
    int cycle = 0;
    int last_due = 0;
    int due;
    raster_bus_pkg::bus_addr_t head_addr;
    raster_bus_pkg::bus_addr_t pending_addr [$];
    int pending_due [$];

    // Hash of the whole address, x and y words cut to 12 bits
    function automatic raster_bus_pkg::bus_data_t word_at(
        input raster_bus_pkg::bus_addr_t addr,
        input raster_bus_pkg::bus_addr_t base
    );
        raster_bus_pkg::bus_data_t h;
        int offset;
        h = 32'(addr) * 32'h9e3779b1;
        h = h ^ (h >> 13) ^ 32'h5bd1e995;
        offset = ((int'(addr) - int'(base)) / raster_bus_pkg::word_bytes - 1) %
                 raster_vertex_pkg::vertex_words;
        if (offset == raster_vertex_pkg::x_word || offset == raster_vertex_pkg::y_word) begin
            h = h & 32'h0000_0fff;
        end
        return h;
    endfunction

    // Accepted reads get an in-order return slot
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending_addr.delete();
            pending_due.delete();
            cycle    = 0;
            last_due = 0;
        end else begin
            cycle = cycle + 1;
            if (read && !waitrequest) begin
                due = cycle + 1 + ($unsigned($random(seed)) % (int'(max_delay) + 1));
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pending_addr.push_back(address);
                pending_due.push_back(due);
            end
        end
    end

    always @(negedge clock or negedge reset) begin
        if (!reset) begin
            waitrequest   = 1'b0;
            readdatavalid = 1'b0;
            readdata      = '0;
        end else begin
            waitrequest = ($unsigned($random(seed)) % 100) < wait_pct;
            if (pending_due.size() > 0 && pending_due[0] <= cycle) begin
                head_addr     = pending_addr.pop_front();
                pending_due.delete(0);
                readdata      = (head_addr == buffer_base) ? tri_count :
                                word_at(head_addr, buffer_base);
                readdatavalid = 1'b1;
            end else begin
                readdatavalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/raster_bus_pkg.sv
`default_nettype none

package raster_bus_pkg;

    // Byte address width of the read master
    localparam int addr_w = 26;

    // Address step from one bus word to the next
    localparam int word_bytes = 4;

    typedef logic [addr_w-1:0] bus_addr_t;
    typedef logic [31:0]       bus_data_t;
    typedef logic [3:0]        bus_be_t;

endpackage

`default_nettype wire

// File: logic/raster_front_end.sv
`timescale 1ns/1ps
`default_nettype none

module raster_front_end (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        fetch_enable,
    input  raster_bus_pkg::bus_addr_t   vertex_buffer_base,
    output raster_bus_pkg::bus_addr_t   master_address,
    output logic                        master_read,
    output raster_bus_pkg::bus_be_t     master_byteenable,
    input  raster_bus_pkg::bus_data_t   master_readdata,
    input  logic                        master_readdatavalid,
    input  logic                        master_waitrequest,
    input  logic                        stall_in,
    output logic                        done_out,
    output logic                        triangle_valid,
    output raster_vertex_pkg::record_t  triangle_record,
    output raster_vertex_pkg::coord_t   bbox_min_x,
    output raster_vertex_pkg::coord_t   bbox_max_x,
    output raster_vertex_pkg::coord_t   bbox_min_y,
    output raster_vertex_pkg::coord_t   bbox_max_y
);

    logic                       record_valid;
    logic                       record_pop;
    raster_vertex_pkg::record_t record_head;

    rasterizer_vertex_fetch i_fetch (
        .clock                (clock),
        .reset                (reset),
        .fetch_enable         (fetch_enable),
        .vertex_buffer_base   (vertex_buffer_base),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_byteenable    (master_byteenable),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .master_waitrequest   (master_waitrequest),
        .record_pop           (record_pop),
        .done_out             (done_out),
        .output_valid         (record_valid),
        .vertex_out           (record_head)
    );

    triangle_bbox_setup i_setup (
        .clock            (clock),
        .reset            (reset),
        .record_available (record_valid),
        .record_in        (record_head),
        .stall_in         (stall_in),
        .record_pop       (record_pop),
        .triangle_valid   (triangle_valid),
        .triangle_record  (triangle_record),
        .bbox_min_x       (bbox_min_x),
        .bbox_max_x       (bbox_max_x),
        .bbox_min_y       (bbox_min_y),
        .bbox_max_y       (bbox_max_y)
    );

endmodule

`default_nettype wire

// File: logic/raster_vertex_pkg.sv
`default_nettype none

package raster_vertex_pkg;

    // Record layout, five words per vertex and three vertices
    localparam int vertex_words = 5;
    localparam int record_words = 15;

    // Word offsets inside one vertex
    localparam int x_word = 0;
    localparam int y_word = 1;

    // Record FIFO holds 2**fifo_depth_log2 triangles
    localparam int fifo_depth_log2 = 2;

    // Word k of a record sits at bits 32k+31 down to 32k
    typedef logic [record_words*32-1:0] record_t;
    typedef logic [3:0]                 word_idx_t;
    typedef logic [31:0]                tri_count_t;
    typedef logic [31:0]                coord_t;
    typedef logic [fifo_depth_log2:0]   fifo_level_t;

endpackage

`default_nettype wire

// File: logic/rasterizer_vertex_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer_vertex_fetch (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        fetch_enable,
    input  raster_bus_pkg::bus_addr_t   vertex_buffer_base,
    output raster_bus_pkg::bus_addr_t   master_address,
    output logic                        master_read,
    output raster_bus_pkg::bus_be_t     master_byteenable,
    input  raster_bus_pkg::bus_data_t   master_readdata,
    input  logic                        master_readdatavalid,
    input  logic                        master_waitrequest,
    input  logic                        record_pop,
    output logic                        done_out,
    output logic                        output_valid,
    output raster_vertex_pkg::record_t  vertex_out
);

    typedef enum logic [1:0] {req_idle, req_count, req_record} req_state_t;
    typedef enum logic {rsp_wait_count, rsp_collect} rsp_state_t;

    req_state_t req_state;
    rsp_state_t rsp_state;

    raster_vertex_pkg::word_idx_t   req_word;
    raster_vertex_pkg::word_idx_t   rsp_word;
    raster_vertex_pkg::tri_count_t  tri_count;
    raster_vertex_pkg::tri_count_t  records_issued;
    raster_vertex_pkg::tri_count_t  records_written;
    raster_vertex_pkg::fifo_level_t in_flight;
    raster_vertex_pkg::fifo_level_t fifo_level;
    raster_vertex_pkg::record_t     record_buf;

    logic count_valid;
    logic record_write;
    logic fifo_empty;
    logic fifo_full;
    logic credit_ok;
    logic record_start;
    logic last_req_word;
    logic last_rsp_word;

    assign master_byteenable = '1;

    assign last_req_word = (req_word == raster_vertex_pkg::word_idx_t'(
                            raster_vertex_pkg::record_words - 1));
    assign last_rsp_word = (rsp_word == raster_vertex_pkg::word_idx_t'(
                            raster_vertex_pkg::record_words - 1));

    // Records in flight plus stored records must stay below the depth
    assign credit_ok = !fifo_full &&
                       ((in_flight + fifo_level) <
                        raster_vertex_pkg::fifo_level_t'(2**raster_vertex_pkg::fifo_depth_log2));

    assign record_start = (req_state == req_record) && !master_read && count_valid &&
                          (records_issued != tri_count) && credit_ok;

    assign done_out = count_valid && (records_written == tri_count);

    ////////////////////
    // Request side
    ////////////////////

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            req_state      <= req_idle;
            master_read    <= 1'b0;
            master_address <= '0;
            req_word       <= '0;
            records_issued <= '0;
        end else begin
            case (req_state)
                req_idle: begin
                    if (fetch_enable) begin
                        master_address <= vertex_buffer_base;
                        master_read    <= 1'b1;
                        req_state      <= req_count;
                    end
                end
                req_count: begin
                    if (!master_waitrequest) begin
                        master_read    <= 1'b0;
                        master_address <= master_address +
                            raster_bus_pkg::bus_addr_t'(raster_bus_pkg::word_bytes);
                        req_state      <= req_record;
                    end
                end
                req_record: begin
                    if (master_read) begin
                        // Address holds until the slave takes the read
                        if (!master_waitrequest) begin
                            master_address <= master_address +
                                raster_bus_pkg::bus_addr_t'(raster_bus_pkg::word_bytes);
                            if (last_req_word) begin
                                master_read <= 1'b0;
                                req_word    <= '0;
                            end else begin
                                req_word <= req_word + 1'b1;
                            end
                        end
                    end else if (record_start) begin
                        master_read    <= 1'b1;
                        records_issued <= records_issued + 1'b1;
                    end
                end
                default: req_state <= req_idle;
            endcase
        end
    end

    // Credit for records started but not yet in the FIFO
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            in_flight <= '0;
        end else begin
            case ({record_start, record_write})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    ////////////////////
    // Response side
    ////////////////////

    always_ff @(posedge clock) begin
        if (rsp_state == rsp_collect && master_readdatavalid) begin
            record_buf[rsp_word*32 +: 32] <= master_readdata;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rsp_state       <= rsp_wait_count;
            count_valid     <= 1'b0;
            tri_count       <= '0;
            rsp_word        <= '0;
            records_written <= '0;
            record_write    <= 1'b0;
        end else begin
            record_write <= 1'b0;
            case (rsp_state)
                rsp_wait_count: begin
                    if (master_readdatavalid) begin
                        tri_count   <= master_readdata;
                        count_valid <= 1'b1;
                        rsp_state   <= rsp_collect;
                    end
                end
                rsp_collect: begin
                    if (master_readdatavalid) begin
                        if (last_rsp_word) begin
                            rsp_word        <= '0;
                            record_write    <= 1'b1;
                            records_written <= records_written + 1'b1;
                        end else begin
                            rsp_word <= rsp_word + 1'b1;
                        end
                    end
                end
                default: rsp_state <= rsp_wait_count;
            endcase
        end
    end

    vertex_record_fifo i_fifo (
        .clock      (clock),
        .reset      (reset),
        .write      (record_write),
        .write_data (record_buf),
        .read       (record_pop),
        .read_data  (vertex_out),
        .empty      (fifo_empty),
        .full       (fifo_full),
        .level      (fifo_level)
    );

    assign output_valid = !fifo_empty;

endmodule

`default_nettype wire

// File: logic/triangle_bbox_setup.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_bbox_setup (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        record_available,
    input  raster_vertex_pkg::record_t  record_in,
    input  logic                        stall_in,
    output logic                        record_pop,
    output logic                        triangle_valid,
    output raster_vertex_pkg::record_t  triangle_record,
    output raster_vertex_pkg::coord_t   bbox_min_x,
    output raster_vertex_pkg::coord_t   bbox_max_x,
    output raster_vertex_pkg::coord_t   bbox_min_y,
    output raster_vertex_pkg::coord_t   bbox_max_y
);

    raster_vertex_pkg::coord_t x [3];
    raster_vertex_pkg::coord_t y [3];

    function automatic raster_vertex_pkg::coord_t min3(
        input raster_vertex_pkg::coord_t a,
        input raster_vertex_pkg::coord_t b,
        input raster_vertex_pkg::coord_t c
    );
        raster_vertex_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic raster_vertex_pkg::coord_t max3(
        input raster_vertex_pkg::coord_t a,
        input raster_vertex_pkg::coord_t b,
        input raster_vertex_pkg::coord_t c
    );
        raster_vertex_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Pick x and y of each vertex out of the flat record
    always_comb begin
        for (int v = 0; v < 3; v++) begin
            x[v] = record_in[32*(v*raster_vertex_pkg::vertex_words +
                                 raster_vertex_pkg::x_word) +: 32];
            y[v] = record_in[32*(v*raster_vertex_pkg::vertex_words +
                                 raster_vertex_pkg::y_word) +: 32];
        end
    end

    // Output register free or draining this cycle
    assign record_pop = record_available && (!triangle_valid || !stall_in);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            triangle_valid <= 1'b0;
        end else if (record_pop) begin
            triangle_valid <= 1'b1;
        end else if (!stall_in) begin
            triangle_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (record_pop) begin
            triangle_record <= record_in;
            bbox_min_x      <= min3(x[0], x[1], x[2]);
            bbox_max_x      <= max3(x[0], x[1], x[2]);
            bbox_min_y      <= min3(y[0], y[1], y[2]);
            bbox_max_y      <= max3(y[0], y[1], y[2]);
        end
    end

endmodule

`default_nettype wire

// File: logic/vertex_record_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_record_fifo (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            write,
    input  raster_vertex_pkg::record_t      write_data,
    input  logic                            read,
    output raster_vertex_pkg::record_t      read_data,
    output logic                            empty,
    output logic                            full,
    output raster_vertex_pkg::fifo_level_t  level
);

    raster_vertex_pkg::record_t mem [2**raster_vertex_pkg::fifo_depth_log2];

    logic [raster_vertex_pkg::fifo_depth_log2-1:0] wr_ptr;
    logic [raster_vertex_pkg::fifo_depth_log2-1:0] rd_ptr;
    logic do_write;
    logic do_read;

    assign do_write = write && !full;
    assign do_read  = read && !empty;

    assign empty = (level == '0);
    assign full  = level[raster_vertex_pkg::fifo_depth_log2];

    // Head shows through, no read strobe needed to see it
    assign read_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/raster_bus_pkg.sv
logic/raster_vertex_pkg.sv
logic/vertex_record_fifo.sv
logic/rasterizer_vertex_fetch.sv
logic/triangle_bbox_setup.sv
logic/raster_front_end.sv
dv/tb_clock_gen.sv
dv/vertex_memory_model.sv
dv/raster_front_end_assert.sv
dv/raster_front_end_tb.sv
